// File: hw/s2mm_params.svh
`ifndef S2MM_PARAMS_SVH
`define S2MM_PARAMS_SVH

// Byte address width, kept small so the top of memory is reachable
`define S2MM_ADDR_WIDTH 16

// Data bus width in bits
`define S2MM_BUS_WIDTH 64

// log2 of the outstanding write counter range
`define S2MM_LGPIPE 4

// Byte lane bits inside one bus word
`define S2MM_WBLSB 3

`endif

// File: hw/s2mm_pkg.sv
`default_nettype none

`include "s2mm_params.svh"

package s2mm_pkg;

	// Byte address, and its split into bus word and byte lane
	typedef logic [`S2MM_ADDR_WIDTH-1:0] byte_addr_t;
	typedef logic [`S2MM_ADDR_WIDTH-`S2MM_WBLSB-1:0] word_addr_t;
	typedef logic [`S2MM_WBLSB-1:0] lane_t;

	// One bus word and its byte selects
	typedef logic [`S2MM_BUS_WIDTH-1:0] bus_data_t;
	typedef logic [`S2MM_BUS_WIDTH/8-1:0] bus_sel_t;

	// Stream beat byte count, 0 up to a full word
	typedef logic [`S2MM_WBLSB:0] beat_bytes_t;

	// Writes issued but not yet answered
	typedef logic [`S2MM_LGPIPE-1:0] pend_count_t;

	// Transfer size, encoded as in the DMA request register
	typedef enum logic [1:0] {
		SZ_BUS  = 2'd0,
		SZ_32B  = 2'd1,
		SZ_16B  = 2'd2,
		SZ_BYTE = 2'd3
	} xfer_size_e;

endpackage

`default_nettype wire

// File: hw/s2mm_addr_step.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm_addr_step
(
	input  s2mm_pkg::word_addr_t i_word_addr,
	input  s2mm_pkg::lane_t      i_lane,
	input  s2mm_pkg::xfer_size_e i_size,
	input  logic                 i_inc,
	input  logic                 i_advance,
	output s2mm_pkg::byte_addr_t o_next_addr,
	output s2mm_pkg::lane_t      o_next_lane,
	output logic                 o_overflow
);

	localparam int AW = $bits(s2mm_pkg::byte_addr_t);
	localparam int WBLSB = $bits(s2mm_pkg::lane_t);

	logic [AW:0] cur_addr;
	logic [AW:0] step;
	logic [AW:0] sum;
	s2mm_pkg::lane_t clr_bits;

	always_comb
	begin
		cur_addr = {1'b0, i_word_addr, i_lane};
		step = '0;
		clr_bits = '0;
		case (i_size)
		s2mm_pkg::SZ_BYTE: step[0] = 1'b1;
		s2mm_pkg::SZ_16B:
		begin
			step[1] = 1'b1;
			clr_bits[0] = 1'b1;
		end
		s2mm_pkg::SZ_32B:
		begin
			step[2] = 1'b1;
			clr_bits[1:0] = 2'b11;
		end
		default:
		begin
			step[WBLSB] = 1'b1;
			clr_bits = '1;
		end
		endcase

		sum = cur_addr;
		if (i_advance)
		begin
			if (i_inc)
				sum = cur_addr + step;
			else
				sum[WBLSB-1:0] = cur_addr[WBLSB-1:0] & ~clr_bits;
		end
	end

	// Carry past the top bit means the next write would wrap
	assign o_next_addr = sum[AW-1:0];
	assign o_next_lane = sum[WBLSB-1:0];
	assign o_overflow = sum[AW];

	// Fixed-address transfers must have been latched already aligned
	always_comb
	begin
		if (i_advance && !i_inc)
			assert final (sum == cur_addr)
			else $error("fixed address not aligned: %h", cur_addr);
	end

endmodule

`default_nettype wire

// File: hw/s2mm_pack.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm_pack
(
	input  logic                  i_clk,
	input  logic                  i_clear,
	input  logic                  i_load,
	input  logic                  i_beat_valid,
	input  s2mm_pkg::bus_data_t   i_s_data,
	input  s2mm_pkg::beat_bytes_t i_s_bytes,
	input  s2mm_pkg::lane_t       i_lane,
	output s2mm_pkg::bus_data_t   o_wr_data,
	output s2mm_pkg::bus_sel_t    o_wr_sel,
	output logic                  o_carry_pending
);

	localparam int DW = $bits(s2mm_pkg::bus_data_t);
	localparam int NB = $bits(s2mm_pkg::bus_sel_t);

	s2mm_pkg::bus_data_t c_data;
	s2mm_pkg::bus_sel_t c_sel;
	s2mm_pkg::bus_sel_t beat_sel;
	logic [2*DW-1:0] next_data;
	logic [2*NB-1:0] next_sel;

	//////////////////////////////////////////////////////////////////////
	// Merge carry-over with the incoming beat
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		beat_sel = '0;
		for (int k = 0; k < NB; k++)
			if (k < i_s_bytes)
				beat_sel[k] = 1'b1;

		// Only lanes still owed to the bus survive from the carry word
		next_data = {{DW{1'b0}}, c_data};
		for (int k = 0; k < NB; k++)
			if (!c_sel[k])
				next_data[8*k +: 8] = 8'h00;
		next_sel = {{NB{1'b0}}, c_sel};

		if (i_beat_valid)
		begin
			next_data = next_data | ({{DW{1'b0}}, i_s_data} << (8 * i_lane));
			next_sel = next_sel | ({{NB{1'b0}}, beat_sel} << i_lane);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outgoing word and carry registers
	//////////////////////////////////////////////////////////////////////

	// Low half goes out now, high half waits for the next word
	always_ff @(posedge i_clk)
	begin
		if (i_clear)
		begin
			{c_data, o_wr_data} <= '0;
			{c_sel, o_wr_sel} <= '0;
		end
		else if (i_load)
		begin
			{c_data, o_wr_data} <= next_data;
			{c_sel, o_wr_sel} <= next_sel;
		end
	end

	assign o_carry_pending = |c_sel;

	// A load is only asked for with a beat or carry in hand
	a_load_has_sel: assert property (@(posedge i_clk) disable iff (i_clear)
		i_load |=> |o_wr_sel);

endmodule

`default_nettype wire

// File: hw/s2mm_wb_track.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm_wb_track
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_wr_cyc,
	input  logic                  i_issue,
	input  logic                  i_wr_ack,
	input  logic                  i_wr_err,
	output s2mm_pkg::pend_count_t o_outstanding,
	output logic                  o_pipe_full
);

	localparam int PW = $bits(s2mm_pkg::pend_count_t);

	s2mm_pkg::pend_count_t count;

	// A bus error abandons every write still in flight
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wr_cyc || i_wr_err)
			count <= '0;
		else
		begin
			case ({i_issue, i_wr_ack})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	assign o_outstanding = count;

	// Full one short of the top, so a stalled stb can still land
	assign o_pipe_full = &count[PW-1:1];

	// Controller must stop before the counter would wrap
	a_no_issue_sat: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wr_cyc && (&count)) |-> !i_issue);

	// Slave answers only writes it has accepted
	a_no_stray_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wr_cyc && count == '0) |-> !(i_wr_ack || i_wr_err));

endmodule

`default_nettype wire

// File: hw/s2mm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm_ctrl
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_request,
	input  logic                  i_inc,
	input  s2mm_pkg::xfer_size_e  i_size,
	input  s2mm_pkg::byte_addr_t  i_addr,
	output logic                  o_busy,
	output logic                  o_err,
	input  logic                  i_s_valid,
	input  logic                  i_s_last,
	output logic                  o_s_ready,
	output logic                  o_wr_cyc,
	output logic                  o_wr_stb,
	output s2mm_pkg::word_addr_t  o_wr_addr,
	input  logic                  i_wr_stall,
	input  logic                  i_wr_ack,
	input  logic                  i_wr_err,
	output s2mm_pkg::lane_t       o_lane,
	output logic                  o_cfg_inc,
	output s2mm_pkg::xfer_size_e  o_cfg_size,
	input  s2mm_pkg::byte_addr_t  i_next_addr,
	input  logic                  i_overflow,
	input  logic                  i_carry_pending,
	output logic                  o_pack_load,
	output logic                  o_pack_clear,
	input  s2mm_pkg::pend_count_t i_outstanding,
	input  logic                  i_pipe_full
);

	localparam int AW = $bits(s2mm_pkg::byte_addr_t);
	localparam int WBLSB = $bits(s2mm_pkg::lane_t);
	localparam int PW = $bits(s2mm_pkg::pend_count_t);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN} state_e;

	state_e state;
	logic r_last;
	logic r_ovf;
	logic issue, slot_free, bus_err, ovf_now, want_write, accept;
	logic [PW:0] pend_after;

	//////////////////////////////////////////////////////////////////////
	// Handshake terms
	//////////////////////////////////////////////////////////////////////

	assign issue = o_wr_stb && !i_wr_stall;
	assign slot_free = !o_wr_stb || !i_wr_stall;
	assign bus_err = o_wr_cyc && i_wr_err;
	assign ovf_now = r_ovf || i_overflow;

	// New beat, or leftover bytes after the last one
	assign want_write = (i_s_valid && !r_last) || (r_last && i_carry_pending);

	// Writes still unanswered once this cycle settles
	assign pend_after = {1'b0, i_outstanding} + {{PW{1'b0}}, issue}
		- {{PW{1'b0}}, i_wr_ack};

	assign o_s_ready = (state == S_RUN) && !r_last && slot_free && !i_pipe_full
		&& !bus_err && !ovf_now;
	assign o_pack_load = (state == S_RUN) && slot_free && !i_pipe_full
		&& want_write && !bus_err && !ovf_now;
	assign o_pack_clear = (state == S_IDLE);
	assign accept = i_s_valid && o_s_ready;

	assign o_busy = (state != S_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Transfer FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= S_IDLE;
			o_err <= 1'b0;
			o_wr_cyc <= 1'b0;
			o_wr_stb <= 1'b0;
			r_last <= 1'b0;
			r_ovf <= 1'b0;
		end
		else
		begin
			case (state)
			S_IDLE:
			begin
				o_wr_cyc <= 1'b0;
				o_wr_stb <= 1'b0;
				if (i_request)
				begin
					state <= S_RUN;
					o_err <= 1'b0;
					r_last <= 1'b0;
					r_ovf <= 1'b0;
				end
			end
			S_RUN:
			begin
				if (bus_err)
				begin
					state <= S_IDLE;
					o_err <= 1'b1;
					o_wr_cyc <= 1'b0;
					o_wr_stb <= 1'b0;
				end
				else if (slot_free)
				begin
					o_wr_stb <= 1'b0;
					if (issue)
						r_ovf <= r_ovf | i_overflow;
					if (!i_pipe_full)
					begin
						// Anything left to write past the top is an error
						if (want_write && ovf_now)
							state <= S_DRAIN;
						else if (want_write)
						begin
							o_wr_cyc <= 1'b1;
							o_wr_stb <= 1'b1;
						end
						else if (pend_after == '0)
						begin
							o_wr_cyc <= 1'b0;
							if (r_last)
								state <= S_IDLE;
						end
					end
					if (accept)
						r_last <= i_s_last;
				end
			end
			S_DRAIN:
			begin
				// Let the in-range writes finish before reporting
				if (bus_err || pend_after == '0)
				begin
					state <= S_IDLE;
					o_err <= 1'b1;
					o_wr_cyc <= 1'b0;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// Configuration and running address
	always_ff @(posedge i_clk)
	begin
		if (state == S_IDLE && i_request)
		begin
			o_cfg_inc <= i_inc;
			o_cfg_size <= i_size;
			o_wr_addr <= i_addr[AW-1:WBLSB];
			o_lane <= i_addr[WBLSB-1:0];
		end
		else if (issue)
		begin
			o_wr_addr <= i_next_addr[AW-1:WBLSB];
			o_lane <= i_next_addr[WBLSB-1:0];
		end
	end

	a_idle_no_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_busy |-> !o_wr_cyc);

	// Counter in the tracker has drained by the time busy drops
	a_end_drained: assert property (@(posedge i_clk) disable iff (i_reset)
		$fell(o_busy) |-> (i_outstanding == '0));

endmodule

`default_nettype wire

// File: hw/s2mm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_params.svh"

module s2mm_top
(
	input  logic                                   i_clk,
	input  logic                                   i_reset,
	// DMA request
	input  logic                                   i_request,
	input  logic                                   i_inc,
	input  logic [1:0]                             i_size,
	input  logic [`S2MM_ADDR_WIDTH-1:0]            i_addr,
	output logic                                   o_busy,
	output logic                                   o_err,
	// Byte stream in
	input  logic                                   i_s_valid,
	output logic                                   o_s_ready,
	input  logic [`S2MM_BUS_WIDTH-1:0]             i_s_data,
	input  logic [`S2MM_WBLSB:0]                   i_s_bytes,
	input  logic                                   i_s_last,
	// Wishbone write master
	output logic                                   o_wr_cyc,
	output logic                                   o_wr_stb,
	output logic                                   o_wr_we,
	output logic [`S2MM_ADDR_WIDTH-`S2MM_WBLSB-1:0] o_wr_addr,
	output logic [`S2MM_BUS_WIDTH-1:0]             o_wr_data,
	output logic [`S2MM_BUS_WIDTH/8-1:0]           o_wr_sel,
	input  logic                                   i_wr_stall,
	input  logic                                   i_wr_ack,
	input  logic                                   i_wr_err
);

	s2mm_pkg::xfer_size_e req_size;
	s2mm_pkg::xfer_size_e cfg_size;
	logic cfg_inc;
	s2mm_pkg::lane_t lane;
	s2mm_pkg::lane_t next_lane;
	s2mm_pkg::byte_addr_t next_addr;
	logic addr_overflow;
	logic wr_issue;
	logic pack_load, pack_clear, carry_pending;
	s2mm_pkg::pend_count_t outstanding;
	logic pipe_full;

	assign req_size = s2mm_pkg::xfer_size_e'(i_size);
	assign wr_issue = o_wr_stb && !i_wr_stall;

	// Write-only master
	assign o_wr_we = 1'b1;

	s2mm_ctrl u_ctrl (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_request(i_request), .i_inc(i_inc), .i_size(req_size), .i_addr(i_addr),
		.o_busy(o_busy), .o_err(o_err),
		.i_s_valid(i_s_valid), .i_s_last(i_s_last), .o_s_ready(o_s_ready),
		.o_wr_cyc(o_wr_cyc), .o_wr_stb(o_wr_stb), .o_wr_addr(o_wr_addr),
		.i_wr_stall(i_wr_stall), .i_wr_ack(i_wr_ack), .i_wr_err(i_wr_err),
		.o_lane(lane), .o_cfg_inc(cfg_inc), .o_cfg_size(cfg_size),
		.i_next_addr(next_addr), .i_overflow(addr_overflow),
		.i_carry_pending(carry_pending), .o_pack_load(pack_load),
		.o_pack_clear(pack_clear),
		.i_outstanding(outstanding), .i_pipe_full(pipe_full)
	);

	s2mm_addr_step u_addr_step (
		.i_word_addr(o_wr_addr), .i_lane(lane), .i_size(cfg_size),
		.i_inc(cfg_inc), .i_advance(wr_issue),
		.o_next_addr(next_addr), .o_next_lane(next_lane), .o_overflow(addr_overflow)
	);

	// Ready doubles as beat-valid, since a load without it is a flush
	s2mm_pack u_pack (
		.i_clk(i_clk), .i_clear(pack_clear), .i_load(pack_load),
		.i_beat_valid(o_s_ready), .i_s_data(i_s_data), .i_s_bytes(i_s_bytes),
		.i_lane(next_lane),
		.o_wr_data(o_wr_data), .o_wr_sel(o_wr_sel), .o_carry_pending(carry_pending)
	);

	s2mm_wb_track u_wb_track (
		.i_clk(i_clk), .i_reset(i_reset), .i_wr_cyc(o_wr_cyc), .i_issue(wr_issue),
		.i_wr_ack(i_wr_ack), .i_wr_err(i_wr_err),
		.o_outstanding(outstanding), .o_pipe_full(pipe_full)
	);

endmodule

`default_nettype wire

// File: tb/wb_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_params.svh"

module wb_mem_slave
(
	input  logic                                    i_clk,
	input  logic                                    i_cyc,
	input  logic                                    i_stb,
	input  logic                                    i_we,
	input  logic [`S2MM_ADDR_WIDTH-`S2MM_WBLSB-1:0] i_addr,
	input  logic [`S2MM_BUS_WIDTH-1:0]              i_data,
	input  logic [`S2MM_BUS_WIDTH/8-1:0]            i_sel,
	input  int                                      i_stall_pct,
	input  int                                      i_max_delay,
	input  int                                      i_err_at,
	output logic                                    o_stall,
	output logic                                    o_ack,
	output logic                                    o_err,
	output int                                      o_writes
);

	logic [7:0] mem [0:(1 << `S2MM_ADDR_WIDTH)-1];

	// Answer queue, kept in issue order
	int due_q[$];
	bit bad_q[$];
	int now;
	int due;
	bit bad;

	initial
	begin
		for (int i = 0; i < (1 << `S2MM_ADDR_WIDTH); i++)
			mem[i] = i[7:0] ^ i[15:8] ^ 8'hc3;
		o_stall = 1'b0;
		o_ack = 1'b0;
		o_err = 1'b0;
		o_writes = 0;
		now = 0;
	end

	always @(posedge i_clk)
	begin
		o_ack <= 1'b0;
		o_err <= 1'b0;
		o_stall <= ($urandom % 100) < i_stall_pct;
		if (!i_cyc)
		begin
			due_q.delete();
			bad_q.delete();
		end
		else
		begin
			if (i_stb && !o_stall)
			begin
				bad = (o_writes + 1 == i_err_at);
				o_writes <= o_writes + 1;
				if (!bad && i_we)
					for (int k = 0; k < `S2MM_BUS_WIDTH/8; k++)
						if (i_sel[k])
							mem[{i_addr, k[`S2MM_WBLSB-1:0]}] = i_data[8*k +: 8];
				due = now + $urandom % (i_max_delay + 1);
				if (due_q.size() > 0 && due < due_q[$])
					due = due_q[$];
				due_q.push_back(due);
				bad_q.push_back(bad);
			end
			if (due_q.size() > 0 && due_q[0] <= now)
			begin
				// An error ends the cycle, so nothing after it is answered
				if (bad_q[0])
				begin
					o_err <= 1'b1;
					due_q.delete();
					bad_q.delete();
				end
				else
				begin
					o_ack <= 1'b1;
					void'(due_q.pop_front());
					void'(bad_q.pop_front());
				end
			end
		end
		now = now + 1;
	end

endmodule

`default_nettype wire

// File: tb/tb_s2mm.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_params.svh"

module tb_s2mm;

	localparam int N_XFER = 20;
	localparam int LIMIT = 6 * N_XFER * 160 + 800;
	localparam int MEM_SIZE = 1 << `S2MM_ADDR_WIDTH;

	logic i_clk;
	logic i_reset;
	logic i_request;
	logic i_inc;
	logic [1:0] i_size;
	logic [`S2MM_ADDR_WIDTH-1:0] i_addr;
	logic o_busy;
	logic o_err;
	logic i_s_valid;
	logic o_s_ready;
	logic [`S2MM_BUS_WIDTH-1:0] i_s_data;
	logic [`S2MM_WBLSB:0] i_s_bytes;
	logic i_s_last;
	logic o_wr_cyc;
	logic o_wr_stb;
	logic o_wr_we;
	logic [`S2MM_ADDR_WIDTH-`S2MM_WBLSB-1:0] o_wr_addr;
	logic [`S2MM_BUS_WIDTH-1:0] o_wr_data;
	logic [`S2MM_BUS_WIDTH/8-1:0] o_wr_sel;
	logic i_wr_stall;
	logic i_wr_ack;
	logic i_wr_err;

	int stall_pct;
	int max_delay;
	int err_at;
	int writes;

	logic [7:0] model_mem [0:MEM_SIZE-1];
	logic [63:0] beat_data[$];
	int beat_cnt[$];
	int errors;
	int checks;
	int cycles;
	int pend;
	logic wrap_chk;
	int wrap_word;

	s2mm_top dut0 (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_request(i_request), .i_inc(i_inc), .i_size(i_size), .i_addr(i_addr),
		.o_busy(o_busy), .o_err(o_err),
		.i_s_valid(i_s_valid), .o_s_ready(o_s_ready), .i_s_data(i_s_data),
		.i_s_bytes(i_s_bytes), .i_s_last(i_s_last),
		.o_wr_cyc(o_wr_cyc), .o_wr_stb(o_wr_stb), .o_wr_we(o_wr_we),
		.o_wr_addr(o_wr_addr), .o_wr_data(o_wr_data), .o_wr_sel(o_wr_sel),
		.i_wr_stall(i_wr_stall), .i_wr_ack(i_wr_ack), .i_wr_err(i_wr_err)
	);

	wb_mem_slave slave0 (
		.i_clk(i_clk), .i_cyc(o_wr_cyc), .i_stb(o_wr_stb), .i_we(o_wr_we),
		.i_addr(o_wr_addr), .i_data(o_wr_data), .i_sel(o_wr_sel),
		.i_stall_pct(stall_pct), .i_max_delay(max_delay), .i_err_at(err_at),
		.o_stall(i_wr_stall), .o_ack(i_wr_ack), .o_err(i_wr_err), .o_writes(writes)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("timeout after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus monitors, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		if (!i_reset)
		begin
			if (o_wr_stb && o_wr_sel == '0)
			begin
				$display("ERR o_wr_sel got %h exp nonzero", o_wr_sel);
				errors++;
			end
			if (!o_busy && o_wr_cyc)
			begin
				$display("bus cycle still open while the engine is idle");
				errors++;
			end
			if (!o_wr_cyc)
				pend = 0;
			else
			begin
				if (o_wr_stb && !i_wr_stall)
					pend++;
				if (i_wr_ack || i_wr_err)
					pend--;
			end
			if (pend > 15)
			begin
				$display("more than 15 writes are waiting for an answer");
				errors++;
			end
			if (wrap_chk && o_wr_stb && !i_wr_stall && o_wr_addr < wrap_word)
			begin
				$display("write wrapped below the start, word %h", o_wr_addr);
				errors++;
			end
		end
	end

	function automatic int size_bytes(input logic [1:0] size);
		case (size)
		s2mm_pkg::SZ_BYTE: return 1;
		s2mm_pkg::SZ_16B: return 2;
		s2mm_pkg::SZ_32B: return 4;
		default: return 8;
		endcase
	endfunction

	// Full beats of n bytes, the last one takes the rest
	task automatic build_beats(input int total, input int n);
		int left;
		int c;
		beat_data.delete();
		beat_cnt.delete();
		left = total;
		while (left > 0)
		begin
			c = (left < n) ? left : n;
			beat_data.push_back({$urandom, $urandom});
			beat_cnt.push_back(c);
			left -= c;
		end
	endtask

	task automatic apply_model(input int addr, input logic inc);
		int k;
		int a;
		logic [63:0] w;
		k = 0;
		foreach (beat_cnt[b])
		begin
			w = beat_data[b];
			for (int j = 0; j < beat_cnt[b]; j++)
			begin
				a = inc ? addr + k : addr + j;
				if (a < MEM_SIZE)
					model_mem[a] = w[8*j +: 8];
				k++;
			end
		end
	endtask

	task automatic compare_window(input int lo, input int hi);
		for (int a = lo; a <= hi; a++)
			if (slave0.mem[a] !== model_mem[a])
			begin
				$display("ERR mem[%h] got %h exp %h", a[15:0], slave0.mem[a], model_mem[a]);
				errors++;
			end
		checks++;
	endtask

	task automatic resync_window(input int lo, input int hi);
		for (int a = lo; a <= hi; a++)
			model_mem[a] = slave0.mem[a];
	endtask

	task automatic run_transfer(input int addr, input logic inc, input logic [1:0] size,
		output logic got_err, output logic all_taken);
		int idx;
		logic vld;
		logic acc;
		logic fin;
		@(posedge i_clk);
		i_request <= 1'b1;
		i_inc <= inc;
		i_size <= size;
		i_addr <= 16'(addr);
		do
			@(negedge i_clk);
		while (!o_busy);
		@(posedge i_clk);
		i_request <= 1'b0;
		idx = 0;
		vld = 1'b0;
		acc = 1'b0;
		fin = 1'b0;
		while (!fin)
		begin
			if (acc)
			begin
				idx++;
				vld = 1'b0;
			end
			// Random gaps between beats
			if (!vld && idx < beat_cnt.size() && ($urandom % 4 != 0))
			begin
				vld = 1'b1;
				i_s_data <= beat_data[idx];
				i_s_bytes <= 4'(beat_cnt[idx]);
				i_s_last <= (idx == beat_cnt.size() - 1);
			end
			i_s_valid <= vld;
			@(negedge i_clk);
			acc = vld && o_s_ready;
			if (!o_busy)
				fin = 1'b1;
			else
				@(posedge i_clk);
		end
		got_err = o_err;
		all_taken = (idx == beat_cnt.size());
		@(posedge i_clk);
		i_s_valid <= 1'b0;
	endtask

	// Mode 0 is a good transfer, 1 a bus error, 2 an address overflow
	task automatic do_transfer(input int addr, input logic inc, input logic [1:0] size,
		input int total, input int mode);
		int lo;
		int hi;
		logic got_err;
		logic all_taken;
		logic exp_err;
		build_beats(total, size_bytes(size));
		exp_err = (mode != 0);
		if (mode == 1)
			err_at = writes + 1 + ($urandom % beat_cnt.size());
		else
			apply_model(addr, inc);
		if (mode == 2)
		begin
			wrap_word = addr >> `S2MM_WBLSB;
			wrap_chk = 1'b1;
		end
		run_transfer(addr, inc, size, got_err, all_taken);
		wrap_chk = 1'b0;
		err_at = 0;
		checks++;
		if (got_err !== exp_err)
		begin
			$display("ERR o_err got %h exp %h", got_err, exp_err);
			errors++;
		end
		if (mode == 0 && !all_taken)
		begin
			$display("transfer ended before every beat was taken");
			errors++;
		end
		lo = (addr >= 16) ? addr - 16 : 0;
		hi = inc ? addr + total + 16 : addr + 24;
		if (hi > MEM_SIZE - 1)
			hi = MEM_SIZE - 1;
		if (mode == 1)
			resync_window(lo, hi);
		else
			compare_window(lo, hi);
		if (mode == 2)
			compare_window(0, 63);
	endtask

	task automatic run_test(input int tn, input string name);
		int first_err;
		int n;
		int addr;
		int total;
		int remain;
		int mode;
		logic inc;
		logic [1:0] size;
		first_err = errors;
		max_delay = (tn == 4) ? 40 : 3;
		for (int x = 0; x < N_XFER; x++)
		begin
			// Test 4 alternates heavy stall with a fast bus that fills the pipeline
			stall_pct = (tn != 4) ? 25 : (x % 2 == 0) ? 70 : 5;
			size = 2'(x % 4);
			n = size_bytes(size);
			inc = (tn != 3);
			mode = 0;
			if (tn == 5 && x % 2 == 0)
				mode = 1;
			if (tn == 6)
			begin
				mode = 2;
				if (n == 2 || n == 4)
					remain = n * (1 + $urandom % 4);
				else
					remain = 1 + $urandom % 20;
				addr = MEM_SIZE - remain;
				total = remain + 1 + $urandom % 16;
			end
			else
			begin
				addr = 'h400 + $urandom % 'he000;
				if (!inc || n == 2 || n == 4)
					addr = addr & ~(n - 1);
				total = 1 + $urandom % 40;
			end
			do_transfer(addr, inc, size, total, mode);
		end
		$display("test %0d %s: %0d errors", tn, name, errors - first_err);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h2ad3));
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_inc = 1'b0;
		i_size = 2'd0;
		i_addr = '0;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_bytes = '0;
		i_s_last = 1'b0;
		stall_pct = 0;
		max_delay = 0;
		err_at = 0;
		errors = 0;
		checks = 0;
		cycles = 0;
		pend = 0;
		wrap_chk = 1'b0;
		wrap_word = 0;

		repeat (8) @(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		checks++;
		if ({o_busy, o_err, o_wr_cyc, o_wr_stb, o_s_ready} !== 5'b0)
		begin
			$display("ERR status after reset got %h exp 00",
				{o_busy, o_err, o_wr_cyc, o_wr_stb, o_s_ready});
			errors++;
		end
		$display("test 1 reset: %0d errors", errors);

		for (int a = 0; a < MEM_SIZE; a++)
			model_mem[a] = slave0.mem[a];

		run_test(2, "incrementing");
		run_test(3, "fixed address");
		run_test(4, "back-pressure");
		run_test(5, "bus error");
		run_test(6, "address overflow");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/s2mm_pkg.sv
hw/s2mm_addr_step.sv
hw/s2mm_pack.sv
hw/s2mm_wb_track.sv
hw/s2mm_ctrl.sv
hw/s2mm_top.sv
tb/wb_mem_slave.sv
tb/tb_s2mm.sv
